/* line_code_pkg.sv */
package line_code_pkg;

	typedef logic [8:0] symbol_t; // K flag on top, byte HGFEDCBA below
	typedef logic [9:0] code10_t; // abcdei then fghj
	typedef logic [5:0] code6_t; // abcdei sub-block
	typedef logic [3:0] code4_t; // fghj sub-block
	typedef logic rd_t; // Running disparity, 0 is negative

	localparam rd_t RD_NEG = 1'b0; // Disparity after reset

	localparam logic [4:0] X_K28 = 5'd28; // 5b value shared by all K28.y

	localparam symbol_t K28_1 = 9'h13c; // Preamble comma
	localparam symbol_t K28_5 = 9'h1bc; // Trailer comma
	localparam symbol_t K23_7 = 9'h1f7; // End of frame

	// K28.0 to K28.7 plus K23.7, K27.7, K29.7 and K30.7
	function automatic logic is_ctrl_code(symbol_t s);
		logic [4:0] x;
		logic [2:0] y;
		logic x_7;
		x = s[4:0];
		y = s[7:5];
		x_7 = (x == 5'd23) || (x == 5'd27) || (x == 5'd29) || (x == 5'd30); // Kx.7 family
		return s[8] && ((x == X_K28) || ((y == 3'd7) && x_7));
	endfunction

endpackage

/* frame_pkg.sv */
package frame_pkg;

	// Framing FSM states
	typedef enum logic [1:0] {
		IDLE, // Waiting for start with K28.1
		PREAMBLE, // Counting K28.1 symbols
		PAYLOAD, // Data and control codes
		TRAILER // K28.5 injected here
	} frame_state_t;

	// K28.1 symbols per preamble, start symbol included
	localparam int PREAMBLE_LEN_DEFAULT = 4;

endpackage

/* frame_ctrl.sv */
`timescale 1ns/1ps

module frame_ctrl #(
	parameter int preamble_len = 4 // Needs to be 2 or more
) (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic startin,
	input line_code_pkg::symbol_t datain,
	output logic sym_valid,
	output logic sym_start,
	output line_code_pkg::symbol_t sym
);

	localparam int cnt_w = $clog2(preamble_len + 1); // Fits preamble_len

	frame_pkg::frame_state_t state; // Current frame state
	frame_pkg::frame_state_t next_state;
	logic [cnt_w-1:0] k_count; // K28.1 symbols seen so far
	logic [cnt_w-1:0] next_count;
	logic is_k28_1; // Preamble symbol on input
	logic is_ctrl; // Allowed control code on input

	assign is_k28_1 = (datain == line_code_pkg::K28_1);
	assign is_ctrl = line_code_pkg::is_ctrl_code(datain);

	always_comb begin
		next_state = state;
		next_count = k_count;
		sym_valid = 1'b0;
		sym_start = 1'b0;
		sym = datain; // Pass-through unless injected
		case (state)
			frame_pkg::IDLE: begin
				if (pushin && startin && is_k28_1) begin
					sym_valid = 1'b1;
					sym_start = 1'b1; // First group of frame
					next_count = cnt_w'(1);
					next_state = frame_pkg::PREAMBLE;
				end
			end
			frame_pkg::PREAMBLE: begin
				if (pushin) begin
					if (is_k28_1) begin
						sym_valid = 1'b1;
						if (k_count == cnt_w'(preamble_len - 1)) begin
							next_state = frame_pkg::PAYLOAD; // Preamble complete
						end else begin
							next_count = k_count + 1'b1;
						end
					end else begin
						next_state = frame_pkg::IDLE; // Broken preamble, drop
					end
				end
			end
			frame_pkg::PAYLOAD: begin
				if (pushin) begin
					sym_valid = !datain[8] || is_ctrl; // Unknown K codes dropped
					if (datain == line_code_pkg::K23_7) begin
						next_state = frame_pkg::TRAILER;
					end
				end
			end
			frame_pkg::TRAILER: begin
				sym_valid = 1'b1; // Input ignored here
				sym = line_code_pkg::K28_5;
				next_state = frame_pkg::IDLE;
			end
			default: next_state = frame_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= frame_pkg::IDLE;
			k_count <= '0;
		end else begin
			state <= next_state;
			k_count <= next_count;
		end
	end

	// Preamble count stays within one frame's K28.1 run
	preamble_count_range: assert property (@(posedge clk) disable iff (reset)
		(state == frame_pkg::PREAMBLE)
			|-> (k_count != '0) && (k_count < cnt_w'(preamble_len)));

endmodule

/* enc_5b6b.sv */
`timescale 1ns/1ps

module enc_5b6b (
	input logic [4:0] in5,
	input logic k28,
	input line_code_pkg::rd_t rd,
	output line_code_pkg::code6_t out6
);

	line_code_pkg::code6_t neg6; // Entry for negative disparity
	logic flip; // Use complemented form

	always_comb begin
		case (in5)
			5'd0: neg6 = 6'b100111;
			5'd1: neg6 = 6'b011101;
			5'd2: neg6 = 6'b101101;
			5'd3: neg6 = 6'b110001;
			5'd4: neg6 = 6'b110101;
			5'd5: neg6 = 6'b101001;
			5'd6: neg6 = 6'b011001;
			5'd7: neg6 = 6'b111000; // Balanced but disparity dependent
			5'd8: neg6 = 6'b111001;
			5'd9: neg6 = 6'b100101;
			5'd10: neg6 = 6'b010101;
			5'd11: neg6 = 6'b110100;
			5'd12: neg6 = 6'b001101;
			5'd13: neg6 = 6'b101100;
			5'd14: neg6 = 6'b011100;
			5'd15: neg6 = 6'b010111;
			5'd16: neg6 = 6'b011011;
			5'd17: neg6 = 6'b100011;
			5'd18: neg6 = 6'b010011;
			5'd19: neg6 = 6'b110010;
			5'd20: neg6 = 6'b001011;
			5'd21: neg6 = 6'b101010;
			5'd22: neg6 = 6'b011010;
			5'd23: neg6 = 6'b111010;
			5'd24: neg6 = 6'b110011;
			5'd25: neg6 = 6'b100110;
			5'd26: neg6 = 6'b010110;
			5'd27: neg6 = 6'b110110;
			5'd28: neg6 = 6'b001110;
			5'd29: neg6 = 6'b101110;
			5'd30: neg6 = 6'b011110;
			default: neg6 = 6'b101011; // D.31
		endcase
		if (k28) begin
			neg6 = 6'b001111; // Comma sub-block
		end
	end

	// Unbalanced entries and D.07 swap at positive disparity
	assign flip = rd && (($countones(neg6) != 3) || (in5 == 5'd7));
	assign out6 = flip ? ~neg6 : neg6;

endmodule

/* enc_3b4b.sv */
`timescale 1ns/1ps

module enc_3b4b (
	input logic [2:0] in3,
	input logic alt,
	input line_code_pkg::rd_t rd,
	output line_code_pkg::code4_t out4
);

	line_code_pkg::code4_t neg4; // Entry for negative disparity
	logic flip; // Use complemented form

	always_comb begin
		case (in3)
			3'd0: neg4 = 4'b1011;
			3'd1: neg4 = 4'b1001;
			3'd2: neg4 = 4'b0101;
			3'd3: neg4 = 4'b1100; // Balanced but disparity dependent
			3'd4: neg4 = 4'b1101;
			3'd5: neg4 = 4'b1010;
			3'd6: neg4 = 4'b0110;
			default: neg4 = alt ? 4'b0111 : 4'b1110; // A7 avoids run of five
		endcase
	end

	assign flip = rd && (($countones(neg4) != 2) || (in3 == 3'd3));
	assign out4 = flip ? ~neg4 : neg4;

endmodule

/* code_encoder.sv */
`timescale 1ns/1ps

module code_encoder (
	input logic clk,
	input logic reset,
	input logic sym_valid,
	input logic sym_start,
	input line_code_pkg::symbol_t sym,
	output logic pushout,
	output logic startout,
	output line_code_pkg::code10_t dataout
);

	line_code_pkg::rd_t rd; // Running disparity, kept across frames
	line_code_pkg::rd_t mid_rd; // Disparity after 6b sub-block
	line_code_pkg::rd_t rd_4b; // Disparity seen by 3b/4b table
	line_code_pkg::rd_t next_rd;
	logic [4:0] x_val; // EDCBA
	logic k28; // Any K28.y
	logic alt; // Alternate x.7 select
	line_code_pkg::code6_t out6;
	line_code_pkg::code4_t raw4; // Table output before K28 fix
	line_code_pkg::code4_t out4;
	line_code_pkg::code10_t code;

	assign x_val = sym[4:0];
	assign k28 = sym[8] && (x_val == line_code_pkg::X_K28);

	enc_5b6b u_5b6b (
		.in5(x_val),
		.k28(k28),
		.rd(rd),
		.out6(out6)
	);

	always_comb begin
		if ($countones(out6) > 3) begin
			mid_rd = 1'b1;
		end else if ($countones(out6) < 3) begin
			mid_rd = 1'b0;
		end else begin
			mid_rd = rd; // Balanced block keeps disparity
		end
	end

	// K codes always take A7, data only where P7 would make a run of five
	assign alt = sym[8]
		|| (!mid_rd && ((x_val == 5'd17) || (x_val == 5'd18) || (x_val == 5'd20)))
		|| (mid_rd && ((x_val == 5'd11) || (x_val == 5'd13) || (x_val == 5'd14)));

	// K28 group at positive RD is the complement of the negative one
	assign rd_4b = k28 ? 1'b1 : mid_rd;

	enc_3b4b u_3b4b (
		.in3(sym[7:5]),
		.alt(alt),
		.rd(rd_4b),
		.out4(raw4)
	);

	assign out4 = (k28 && !mid_rd) ? ~raw4 : raw4;
	assign code = {out6, out4};

	always_comb begin
		if ($countones(code) > 5) begin
			next_rd = 1'b1;
		end else if ($countones(code) < 5) begin
			next_rd = 1'b0;
		end else begin
			next_rd = rd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pushout <= 1'b0;
			startout <= 1'b0;
			dataout <= '0;
			rd <= line_code_pkg::RD_NEG;
		end else begin
			pushout <= sym_valid;
			startout <= sym_valid && sym_start;
			if (sym_valid) begin
				dataout <= code;
				rd <= next_rd; // Only emitted groups move disparity
			end
		end
	end

	// Emitted groups never exceed one unit of disparity
	group_weight: assert property (@(posedge clk) disable iff (reset)
		pushout |-> ($countones(dataout) inside {4, 5, 6}));

endmodule

/* framing_encoder.sv */
`timescale 1ns/1ps

module framing_encoder #(
	parameter int preamble_len = frame_pkg::PREAMBLE_LEN_DEFAULT
) (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic startin,
	input line_code_pkg::symbol_t datain,
	output logic pushout,
	output line_code_pkg::code10_t dataout,
	output logic startout
);

	logic sym_valid; // Symbol passed to encoder
	logic sym_start; // First symbol of frame
	line_code_pkg::symbol_t sym;

	frame_ctrl #(
		.preamble_len(preamble_len)
	) u_frame_ctrl (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.sym_valid(sym_valid),
		.sym_start(sym_start),
		.sym(sym)
	);

	code_encoder u_code_encoder (
		.clk(clk),
		.reset(reset),
		.sym_valid(sym_valid),
		.sym_start(sym_start),
		.sym(sym),
		.pushout(pushout),
		.startout(startout),
		.dataout(dataout)
	);

endmodule

/* tb_code_model.svh */
`ifndef TB_CODE_MODEL_SVH
`define TB_CODE_MODEL_SVH

// Standard 5b/6b column at RD-, D.00 first, bits abcdei
localparam logic [0:31][5:0] SIX_MINUS = {
	6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
	6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
	6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
	6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};
localparam logic [0:7][3:0] FOUR_MINUS = {
	4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110 // P7 last
};
localparam logic [0:7][3:0] K28_FOUR = {
	4'b0100, 4'b1001, 4'b0101, 4'b0011, 4'b0010, 4'b1010, 4'b0110, 4'b1000 // K28.y at RD-
};

// More ones than zeros leaves RD positive, fewer leaves it negative
function automatic line_code_pkg::rd_t disparity_after(int ones, int width,
	line_code_pkg::rd_t rd);
	if (2 * ones == width) begin
		return rd; // Balanced block
	end
	return (2 * ones > width);
endfunction

function automatic line_code_pkg::code10_t model_encode(line_code_pkg::symbol_t s,
	line_code_pkg::rd_t rd);
	logic [4:0] x;
	logic [2:0] y;
	line_code_pkg::code6_t six;
	line_code_pkg::code4_t four;
	line_code_pkg::rd_t mid; // RD between sub-blocks
	x = s[4:0];
	y = s[7:5];
	if (s[8] && x == 5'd28) begin
		return rd ? ~{6'b001111, K28_FOUR[y]} : {6'b001111, K28_FOUR[y]}; // Whole group flips
	end
	six = SIX_MINUS[x];
	if (rd && ($countones(six) != 3 || x == 5'd7)) begin
		six = ~six;
	end
	mid = disparity_after($countones(six), 6, rd);
	four = FOUR_MINUS[y];
	if (y == 3'd7 && (s[8] || (!mid && x inside {17, 18, 20})
		|| (mid && x inside {11, 13, 14}))) begin
		four = 4'b0111; // A7 form
	end
	if (mid && ($countones(four) != 2 || y == 3'd3)) begin
		four = ~four;
	end
	return {six, four};
endfunction

`endif

/* tb_framing_encoder.sv */
`timescale 1ns/1ps

module tb_framing_encoder;

	`include "tb_code_model.svh"

	// Reset, open, data, control, close, abort, gaps, flush
	localparam int TEST_CYCLES = 4 + 4 + 88 + 12 + 3 + 9 + 7 + 1;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;
	localparam logic [0:5][4:0] A7_CASES = {5'd11, 5'd13, 5'd14, 5'd17, 5'd18, 5'd20};

	logic clk;
	logic reset;
	logic pushin;
	logic startin;
	line_code_pkg::symbol_t datain;
	logic pushout;
	logic startout;
	line_code_pkg::code10_t dataout;

	logic pend_push; // Expected at next check
	logic pend_start;
	line_code_pkg::code10_t pend_code;
	line_code_pkg::rd_t tb_rd; // Model RD since reset
	int cycle_count = 0;

	framing_encoder #(
		.preamble_len(frame_pkg::PREAMBLE_LEN_DEFAULT)
	) DUT (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.pushout(pushout),
		.dataout(dataout),
		.startout(startout)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout, run passed %0d cycles", cycle_count);
			$display("Errors found");
			$fatal(1, "Simulation did not finish within its cycle limit");
		end
	end

	task automatic check_code(string name, line_code_pkg::code10_t exp,
		line_code_pkg::code10_t act);
		if (act !== exp) begin
			$display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
			$display("Errors found");
			$fatal(1, "Code group mismatch");
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
			$display("Errors found");
			$fatal(1, "Strobe mismatch");
		end
	endtask

	// Drive one cycle, check the previous cycle's group, then queue this one
	task automatic step_symbol(logic push, logic start, line_code_pkg::symbol_t s,
		logic emit, line_code_pkg::symbol_t enc);
		@(posedge clk);
		pushin <= push;
		startin <= start;
		datain <= s;
		@(negedge clk); // Outputs settled
		check_flag("pushout", pend_push, pushout);
		check_flag("startout", pend_start, startout);
		if (pend_push) begin
			check_code("dataout", pend_code, dataout);
		end
		pend_push = emit;
		pend_start = emit && start;
		if (emit) begin
			pend_code = model_encode(enc, tb_rd);
			tb_rd = disparity_after($countones(pend_code), 10, tb_rd);
		end
	endtask

	// D.0.1 is unbalanced, so it toggles RD
	task automatic set_disparity(line_code_pkg::rd_t want);
		if (tb_rd != want) begin
			step_symbol(1'b1, 1'b0, 9'h020, 1'b1, 9'h020);
		end
	endtask

	task automatic test_frame_open();
		step_symbol(1'b1, 1'b1, line_code_pkg::K28_1, 1'b1, line_code_pkg::K28_1);
		repeat (frame_pkg::PREAMBLE_LEN_DEFAULT - 1) begin
			step_symbol(1'b1, 1'b0, line_code_pkg::K28_1, 1'b1, line_code_pkg::K28_1);
		end
	endtask

	task automatic test_data_bytes();
		line_code_pkg::symbol_t s;
		repeat (64) begin
			s = {1'b0, 8'($urandom())};
			step_symbol(1'b1, 1'b0, s, 1'b1, s);
		end
		for (int i = 0; i < 6; i++) begin
			for (int r = 0; r < 2; r++) begin
				set_disparity(r[0]); // A7 and P7 side of each case
				s = {1'b0, 3'd7, A7_CASES[i]};
				step_symbol(1'b1, 1'b0, s, 1'b1, s);
			end
		end
	endtask

	task automatic test_control_codes();
		line_code_pkg::symbol_t s;
		for (int y = 0; y < 8; y++) begin
			s = {1'b1, 3'(y), 5'd28}; // K28.y
			step_symbol(1'b1, 1'b0, s, 1'b1, s);
		end
		step_symbol(1'b1, 1'b0, 9'h1fb, 1'b1, 9'h1fb); // K27.7
		step_symbol(1'b1, 1'b0, 9'h1fd, 1'b1, 9'h1fd); // K29.7
		step_symbol(1'b1, 1'b0, 9'h1fe, 1'b1, 9'h1fe); // K30.7
		step_symbol(1'b1, 1'b0, 9'h1b5, 1'b0, '0); // K21.5 not in set
	endtask

	task automatic test_frame_close();
		step_symbol(1'b1, 1'b0, line_code_pkg::K23_7, 1'b1, line_code_pkg::K23_7);
		step_symbol(1'b0, 1'b0, '0, 1'b1, line_code_pkg::K28_5); // Trailer on its own
		step_symbol(1'b1, 1'b0, 9'h055, 1'b0, '0); // Idle, no start
	endtask

	task automatic test_preamble_abort();
		step_symbol(1'b1, 1'b1, line_code_pkg::K28_1, 1'b1, line_code_pkg::K28_1);
		step_symbol(1'b1, 1'b0, 9'h0a5, 1'b0, '0); // Breaks preamble
		step_symbol(1'b1, 1'b0, line_code_pkg::K28_1, 1'b0, '0); // Back in idle
		test_frame_open();
		step_symbol(1'b1, 1'b0, 9'h0c3, 1'b1, 9'h0c3);
		step_symbol(1'b1, 1'b0, 9'h03c, 1'b1, 9'h03c);
	endtask

	task automatic test_gaps();
		step_symbol(1'b1, 1'b0, 9'h0e7, 1'b1, 9'h0e7);
		step_symbol(1'b0, 1'b0, line_code_pkg::K23_7, 1'b0, '0); // End code without push
		step_symbol(1'b0, 1'b0, 9'h011, 1'b0, '0);
		step_symbol(1'b1, 1'b0, 9'h0f1, 1'b1, 9'h0f1);
		step_symbol(1'b1, 1'b0, 9'h02b, 1'b1, 9'h02b);
		step_symbol(1'b1, 1'b0, line_code_pkg::K23_7, 1'b1, line_code_pkg::K23_7);
		step_symbol(1'b0, 1'b0, '0, 1'b1, line_code_pkg::K28_5);
	endtask

	initial begin
		void'($urandom(32'hfc64));
		clk = 1'b0;
		reset = 1'b1;
		pushin = 1'b0;
		startin = 1'b0;
		datain = '0;
		pend_push = 1'b0;
		pend_start = 1'b0;
		pend_code = '0;
		tb_rd = 1'b0; // RD- after reset
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		test_frame_open();
		test_data_bytes();
		test_control_codes();
		test_frame_close();
		test_preamble_abort();
		test_gaps();
		step_symbol(1'b0, 1'b0, '0, 1'b0, '0); // Flush last group
		$display("No errors");
		$finish;
	end

endmodule

/* framing_encoder.f */
+incdir+.
line_code_pkg.sv
frame_pkg.sv
frame_ctrl.sv
enc_5b6b.sv
enc_3b4b.sv
code_encoder.sv
framing_encoder.sv
tb_framing_encoder.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_framing_encoder \
		-f framing_encoder.f -o sim

run: compile
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
